// File: project.f
+incdir+tb
design/cpuPkg.sv
design/controlUnit.sv
design/regBank.sv
design/aluUnit.sv
design/cpuTop.sv
tb/cpuTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the run from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cpuTb -f project.f -o cpuTbSim \
    && ./obj_dir/cpuTbSim > sim.log 2>&1 \
    || echo "** FAIL **" >> sim.log
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && echo "Simulation failed" && exit 1
echo "Simulation passed"
exit 0

// File: tb/tbProgram.svh
function automatic instr_t regInstr(opcode_t op, regCode_t dst, regCode_t srcA, regCode_t srcB);
    return {op, dst, srcA, srcB};
endfunction

// Immediate or direct form, regSel picks R1-R4
function automatic instr_t memInstr(opcode_t op, logic direct, logic [1:0] sel, byte_t imm);
    return {op, 1'b0, direct, sel, imm};
endfunction

task automatic expectAccess(byte_t where, logic wr, byte_t data);
    trace[traceLen] = '{addr: where, wrData: data, csN: 1'b0, wr: wr};
    traceLen = traceLen + 8'd1;
endtask

// Low byte first, untraced slots are never fetched
task automatic place(instr_t ins, logic traced);
    byte_t hiAddr;
    hiAddr = pcModel + 8'd1;
    image[pcModel]  = ins[7:0];
    image[hiAddr]   = ins[15:8];
    refMem[pcModel] = ins[7:0];
    refMem[hiAddr]  = ins[15:8];
    if (traced) begin
        expectAccess(pcModel, 1'b0, 8'h00);
        expectAccess(hiAddr, 1'b0, 8'h00);
        nInstr++;
    end
    pcModel = pcModel + 8'd2;
endtask

task automatic doAlu(opcode_t op, regCode_t dst, regCode_t srcA, regCode_t srcB);
    byte_t a;
    byte_t b;
    byte_t res;
    a = regs[srcA[2:0]];
    b = regs[srcB[2:0]];
    case (op)
        opAnd:   res = a & b;
        opOr:    res = a | b;
        opNot:   res = ~a;
        opAdd:   res = a + b;
        opSub:   res = a - b;
        opLsr:   res = a >> 1;
        opLsl:   res = a << 1;
        default: res = a;  // MOV copies source 1
    endcase
    place(regInstr(op, dst, srcA, srcB), 1'b1);
    regs[dst[2:0]] = res;
    zModel = (res == 8'h00);
endtask

task automatic ldImm(logic [1:0] sel, byte_t value);
    place(memInstr(opLd, 1'b0, sel, value), 1'b1);
    regs[{1'b1, sel}] = value;
endtask

task automatic ldDir(logic [1:0] sel);
    place(memInstr(opLd, 1'b1, sel, 8'h00), 1'b1);
    expectAccess(regs[1], 1'b0, 8'h00);
    regs[{1'b1, sel}] = refMem[regs[1]];
endtask

task automatic store(logic [1:0] sel);
    place(memInstr(opSt, 1'b1, sel, 8'h00), 1'b1);
    expectAccess(regs[1], 1'b1, regs[{1'b1, sel}]);
    refMem[regs[1]] = regs[{1'b1, sel}];
endtask

// Jumps over one store slot when taken
task automatic skipBranch(opcode_t op);
    logic taken;
    taken = (op == opBra) || !zModel;
    place(memInstr(op, 1'b0, 2'd0, pcModel + 8'd4), 1'b1);
    if (taken) begin
        place(memInstr(opSt, 1'b1, 2'd0, 8'h00), 1'b0);
    end else begin
        store(2'd0);
    end
endtask

task automatic buildProgram();
    opcode_t aluOps [8];
    byte_t   loopAddr;
    aluOps = '{opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opMov};
    for (int a = 0; a < 256; a++) begin
        image[a]  = byte_t'($urandom);
        refMem[a] = image[a];
    end
    for (int r = 0; r < 8; r++) begin
        regs[r] = 8'h00;
    end
    pcModel = 8'h00;
    zModel  = 1'b0;
    for (int i = 0; i < 8; i++) begin
        ldImm(2'd2, 8'hC0 | byte_t'($urandom));  // Data region above the code
        doAlu(opMov, codeAr, codeR3, codeR3);
        ldImm(2'd0, byte_t'($urandom));
        ldImm(2'd1, byte_t'($urandom));
        doAlu(aluOps[i], codeR4, codeR1, codeR2);
        store(2'd3);
    end
    ldImm(2'd2, 8'hC0 | byte_t'($urandom));
    doAlu(opMov, codeAr, codeR3, codeR3);
    ldDir(2'd1);
    ldImm(2'd2, 8'hC0 | byte_t'($urandom));
    doAlu(opMov, codeAr, codeR3, codeR3);
    store(2'd1);
    ldImm(2'd0, byte_t'($urandom) | 8'h01);
    doAlu(opSub, codeR4, codeR1, codeR1);  // Zero result
    skipBranch(opBne);
    doAlu(opOr, codeR4, codeR1, codeR1);
    place(regInstr(opInc, codeR1, codeR1, codeR1), 1'b1);
    place(regInstr(opDec, codeR1, codeR1, codeR1), 1'b1);
    place(regInstr(opPsh, codeR1, codeR1, codeR1), 1'b1);
    place(regInstr(opPul, codeR1, codeR1, codeR1), 1'b1);
    place(memInstr(opSt, 1'b0, 2'd0, 8'hC0), 1'b1);
    place(memInstr(opBra, 1'b1, 2'd0, 8'h00), 1'b1);
    store(2'd0);
    skipBranch(opBne);  // Z still clear after the no-ops
    skipBranch(opBra);
    loopAddr = pcModel;
    place(memInstr(opBra, 1'b0, 2'd0, loopAddr), 1'b1);
    expectAccess(loopAddr, 1'b0, 8'h00);
    expectAccess(loopAddr + 8'd1, 1'b0, 8'h00);
endtask

// File: tb/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int       clkPeriod   = 40;
    localparam int       resetCycles = 5;
    localparam regCode_t codeAr      = 4'h1;
    localparam regCode_t codeR1      = 4'h4;
    localparam regCode_t codeR2      = 4'h5;
    localparam regCode_t codeR3      = 4'h6;
    localparam regCode_t codeR4      = 4'h7;

    logic    clk = 1'b0;
    logic    rstN;
    memReq_t memReq;
    byte_t   memRdData;

    byte_t   mem [256];     // Memory seen by the DUT
    byte_t   image [256];   // Initial contents, loaded during reset
    byte_t   refMem [256];  // Reference model view of memory
    byte_t   regs [8];      // Model registers by code bits [2:0]
    byte_t   pcModel;
    logic    zModel;
    memReq_t trace [256];   // Expected bus accesses in order
    logic [7:0] traceLen = '0;
    logic [7:0] accessIdx = '0;
    int      nInstr = 0;
    logic    built = 1'b0;
    logic    resetSeen = 1'b0;
    memReq_t expected;
    logic    tracing;

    int resetErrors = 0;
    int kindErrors  = 0;
    int addrErrors  = 0;
    int dataErrors  = 0;

    `include "tbProgram.svh"

    always #(clkPeriod / 2) clk = ~clk;

    cpuTop i_cpuTop (
        .clk       (clk),
        .rstN      (rstN),
        .memReq    (memReq),
        .memRdData (memRdData)
    );

    assign memRdData = mem[memReq.addr];  // Combinational read
    assign expected  = trace[accessIdx];
    assign tracing   = rstN && (accessIdx != traceLen);

    always @(posedge clk) begin
        if (!rstN) begin
            mem <= image;
        end else if (!memReq.csN && memReq.wr) begin
            mem[memReq.addr] <= memReq.wrData;
        end
    end

    always @(posedge clk) begin
        resetSeen <= !rstN;
        if (tracing && !memReq.csN) begin
            accessIdx <= accessIdx + 8'd1;  // Next expected access
        end
    end

    resetQuiet: assert property (@(posedge clk) (!rstN && resetSeen) |-> memReq.csN)
        else begin
            resetErrors++;
            $display("** Error (%0t ns): chip select active during reset", $time);
        end

    accessKind: assert property (@(posedge clk)
        (tracing && !memReq.csN) |-> memReq.wr == expected.wr)
        else begin
            kindErrors++;
            $display("** Error (%0t ns): access %0d has wr %b, expected %b", $time,
                $sampled(accessIdx), $sampled(memReq.wr), $sampled(expected.wr));
        end

    accessAddr: assert property (@(posedge clk)
        (tracing && !memReq.csN) |-> memReq.addr == expected.addr)
        else begin
            addrErrors++;
            $display("** Error (%0t ns): access %0d at address %h, expected %h", $time,
                $sampled(accessIdx), $sampled(memReq.addr), $sampled(expected.addr));
        end

    storeData: assert property (@(posedge clk)
        (tracing && !memReq.csN && memReq.wr) |-> memReq.wrData == expected.wrData)
        else begin
            dataErrors++;
            $display("** Error (%0t ns): store of %h at %h, expected %h", $time,
                $sampled(memReq.wrData), $sampled(memReq.addr), $sampled(expected.wrData));
        end

    initial begin
        void'($urandom(32'h6348));
        rstN = 1'b0;
        buildProgram();
        built = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #2;
        rstN = 1'b1;
        wait (accessIdx == traceLen);  // Whole trace seen on the bus
        @(posedge clk);
        #1;
        $display("Errors: reset %0d, access kind %0d, address %0d, store data %0d",
            resetErrors, kindErrors, addrErrors, dataErrors);
        if (resetErrors + kindErrors + addrErrors + dataErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Twice the time the traced instructions need, reset included
    initial begin
        wait (built);
        #((nInstr * 3 + resetCycles + 2) * clkPeriod * 2);
        $display("Timeout: the CPU stopped after %0d of %0d expected bus accesses",
            accessIdx, traceLen);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: design/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic            clk,
    input  logic            rstN,
    output cpuPkg::memReq_t memReq,
    input  cpuPkg::byte_t   memRdData
);
    import cpuPkg::*;

    ctrlWord_t ctrl;
    byte_t     immediate;
    byte_t     operandA;
    byte_t     operandB;  // Doubles as store data
    byte_t     memAddr;
    byte_t     aluResult;
    logic      zFlag;

    controlUnit i_controlUnit (
        .clk       (clk),
        .rstN      (rstN),
        .memRdData (memRdData),
        .zFlag     (zFlag),
        .ctrl      (ctrl),
        .immediate (immediate)
    );

    regBank i_regBank (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .memRdData (memRdData),
        .immediate (immediate),
        .operandA  (operandA),
        .operandB  (operandB),
        .memAddr   (memAddr)
    );

    aluUnit i_aluUnit (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .operandA (operandA),
        .operandB (operandB),
        .result   (aluResult),
        .zFlag    (zFlag)
    );

    // Chip select follows any access
    assign memReq = '{
        addr:   memAddr,
        wrData: operandB,
        csN:    !(ctrl.memRead || ctrl.memWrite),
        wr:     ctrl.memWrite
    };

endmodule

// File: design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic              clk,
    input  logic              rstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::byte_t     operandA,
    input  cpuPkg::byte_t     operandB,
    output cpuPkg::byte_t     result,
    output logic              zFlag
);
    import cpuPkg::*;

    logic [dataWidth:0] wide;  // Extra bit for carry or borrow
    logic               carry;
    logic               overflow;
    flags_t             nextFlags;
    flags_t             flags;

    always_comb begin
        wide     = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        result   = operandA;
        case (ctrl.aluOp)
            aluAnd: result = operandA & operandB;
            aluOr:  result = operandA | operandB;
            aluNot: result = ~operandA;
            aluAdd: begin
                wide     = {1'b0, operandA} + {1'b0, operandB};
                result   = wide[dataWidth-1:0];
                carry    = wide[dataWidth];
                overflow = (operandA[dataWidth-1] == operandB[dataWidth-1])
                        && (result[dataWidth-1] != operandA[dataWidth-1]);
            end
            aluSub: begin
                wide     = {1'b0, operandA} - {1'b0, operandB};
                result   = wide[dataWidth-1:0];
                carry    = !wide[dataWidth];  // Set when no borrow
                overflow = (operandA[dataWidth-1] != operandB[dataWidth-1])
                        && (result[dataWidth-1] != operandA[dataWidth-1]);
            end
            aluLsl: begin
                carry  = operandA[dataWidth-1];
                result = {operandA[dataWidth-2:0], 1'b0};
            end
            aluLsr: begin
                carry  = operandA[0];
                result = {1'b0, operandA[dataWidth-1:1]};
            end
            default: result = operandA;  // Pass for MOV
        endcase
        nextFlags.z = (result == '0);
        nextFlags.c = carry;
        nextFlags.n = result[dataWidth-1];
        nextFlags.o = overflow;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags <= '0;
        end else if (ctrl.flagsEn) begin
            flags <= nextFlags;
        end
    end

    assign zFlag = flags.z;

endmodule

// File: design/regBank.sv
`timescale 1ns/1ps

module regBank (
    input  logic              clk,
    input  logic              rstN,
    input  cpuPkg::ctrlWord_t ctrl,
    input  cpuPkg::byte_t     aluResult,
    input  cpuPkg::byte_t     memRdData,
    input  cpuPkg::byte_t     immediate,
    output cpuPkg::byte_t     operandA,
    output cpuPkg::byte_t     operandB,
    output cpuPkg::byte_t     memAddr
);
    import cpuPkg::*;

    byte_t gpr [4];      // R1-R4
    byte_t ar;
    byte_t sp;
    byte_t pc;
    byte_t regView [8];  // Indexed by register code bits [2:0]
    byte_t wrData;
    logic  wrPc;

    // Register code decode for the read ports
    always_comb begin
        regView[0] = sp;
        regView[1] = ar;
        regView[2] = pc;
        regView[3] = pc;  // 11 aliases PC
        for (int i = 0; i < 4; i++) begin
            regView[4+i] = gpr[i];
        end
    end

    assign operandA = regView[ctrl.rdCodeA[2:0]];
    assign operandB = regView[ctrl.rdCodeB[2:0]];

    always_comb begin
        case (ctrl.wrSrc)
            wrMem:   wrData = memRdData;
            wrImm:   wrData = immediate;
            default: wrData = aluResult;
        endcase
    end

    assign memAddr = (ctrl.addrSel == addrAr) ? ar : pc;

    // A register write aimed at PC overrides load and increment
    assign wrPc = ctrl.regWrEn && !ctrl.regWrCode[2] && ctrl.regWrCode[1];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            gpr <= '{default: '0};
            ar  <= '0;
            sp  <= '0;
            pc  <= '0;
        end else begin
            if (ctrl.regWrEn) begin
                if (ctrl.regWrCode[2]) begin
                    gpr[ctrl.regWrCode[1:0]] <= wrData;
                end else if (ctrl.regWrCode[1:0] == 2'b00) begin
                    sp <= wrData;
                end else if (ctrl.regWrCode[1:0] == 2'b01) begin
                    ar <= wrData;
                end
            end
            if (wrPc) begin
                pc <= wrData;
            end else if (ctrl.pcLoad) begin
                pc <= immediate;  // Branch target
            end else if (ctrl.pcInc) begin
                pc <= pc + 1'b1;
            end
        end
    end

    pcUpdateOne: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.pcInc && ctrl.pcLoad))
        else $error("pcInc and pcLoad both set");

endmodule

// File: design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic              clk,
    input  logic              rstN,
    input  cpuPkg::byte_t     memRdData,
    input  logic              zFlag,
    output cpuPkg::ctrlWord_t ctrl,
    output cpuPkg::byte_t     immediate
);
    import cpuPkg::*;

    seqState_t  state;
    logic       running;  // Low for one cycle after reset
    instr_t     ir;
    opcode_t    opcode;
    regCode_t   dstCode;
    regCode_t   srcCode1;
    regCode_t   srcCode2;
    logic       addrMode;  // 1 direct, 0 immediate
    logic [1:0] regSel;
    regCode_t   selCode;

    function automatic aluOp_t aluOpFor(opcode_t op);
        case (op)
            opAnd:   return aluAnd;
            opOr:    return aluOr;
            opNot:   return aluNot;
            opAdd:   return aluAdd;
            opSub:   return aluSub;
            opLsr:   return aluLsr;
            opLsl:   return aluLsl;
            default: return aluPass;  // MOV
        endcase
    endfunction

    assign opcode    = opcode_t'(ir[15:12]);
    assign dstCode   = ir[11:8];
    assign srcCode1  = ir[7:4];
    assign srcCode2  = ir[3:0];
    assign addrMode  = ir[10];
    assign regSel    = ir[9:8];
    assign selCode   = {2'b01, regSel};  // R1-R4 by regSel
    assign immediate = ir[7:0];

    // Sequence counter and IR
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= t0;
            running <= 1'b0;
            ir      <= '0;
        end else begin
            running <= 1'b1;
            if (running) begin
                case (state)
                    t0:      state <= t1;
                    t1:      state <= t2;
                    default: state <= t0;
                endcase
            end
            if (state == t0 && ctrl.memRead) begin
                ir[7:0] <= memRdData;
            end
            if (state == t1) begin
                ir[15:8] <= memRdData;
            end
        end
    end

    // Control word decode
    always_comb begin
        ctrl         = '0;
        ctrl.aluOp   = aluPass;
        ctrl.wrSrc   = wrAlu;
        ctrl.addrSel = addrPc;
        case (state)
            t0, t1: begin
                ctrl.memRead = running;  // Fetch at PC
                ctrl.pcInc   = running;
            end
            default: begin
                case (opcode)
                    opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opMov: begin
                        ctrl.aluOp     = aluOpFor(opcode);
                        ctrl.flagsEn   = 1'b1;
                        ctrl.regWrEn   = 1'b1;
                        ctrl.regWrCode = dstCode;
                        ctrl.rdCodeA   = srcCode1;
                        ctrl.rdCodeB   = srcCode2;
                    end
                    opLd: begin
                        ctrl.regWrEn   = 1'b1;
                        ctrl.regWrCode = selCode;
                        if (addrMode) begin
                            ctrl.memRead = 1'b1;  // M[AR]
                            ctrl.addrSel = addrAr;
                            ctrl.wrSrc   = wrMem;
                        end else begin
                            ctrl.wrSrc = wrImm;
                        end
                    end
                    opSt: begin
                        // Immediate form falls through as a no-op
                        if (addrMode) begin
                            ctrl.memWrite = 1'b1;
                            ctrl.addrSel  = addrAr;
                            ctrl.rdCodeB  = selCode;  // Store data
                        end
                    end
                    opBra: ctrl.pcLoad = !addrMode;
                    opBne: ctrl.pcLoad = !addrMode && !zFlag;  // Taken on Z clear
                    opInc, opDec, opPsh, opPul: ;  // Retired as no-ops
                endcase
            end
        endcase
    end

    memExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite both set");

    // Writes only in the execute step
    wrInExecute: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.regWrEn |-> state == t2)
        else $error("regWrEn outside T2");

endmodule

// File: design/cpuPkg.sv
package cpuPkg;

    localparam int dataWidth    = 8;
    localparam int instrWidth   = 2 * dataWidth;
    localparam int regCodeWidth = 4;

    typedef logic [dataWidth-1:0]    byte_t;     // Data and addresses
    typedef logic [instrWidth-1:0]   instr_t;    // Two fetched bytes
    typedef logic [regCodeWidth-1:0] regCode_t;  // Bit 2 set picks R1-R4

    // Instruction opcodes, IR[15:12]
    typedef enum logic [3:0] {
        opAnd = 4'h0,
        opOr  = 4'h1,
        opNot = 4'h2,
        opAdd = 4'h3,
        opSub = 4'h4,
        opLsr = 4'h5,
        opLsl = 4'h6,
        opMov = 4'h7,
        opLd  = 4'h8,
        opSt  = 4'h9,
        opBra = 4'hA,
        opBne = 4'hB,
        opInc = 4'hC,
        opDec = 4'hD,
        opPsh = 4'hE,
        opPul = 4'hF
    } opcode_t;

    typedef enum logic [2:0] {
        aluPass,
        aluAnd,
        aluOr,
        aluNot,
        aluAdd,
        aluSub,
        aluLsl,
        aluLsr
    } aluOp_t;

    typedef enum logic [1:0] {
        wrAlu,  // ALU result
        wrMem,  // Memory read data
        wrImm   // IR low byte
    } wrSrc_t;

    typedef enum logic {
        addrPc,
        addrAr
    } addrSel_t;

    typedef enum logic [1:0] {
        t0,  // Fetch low byte
        t1,  // Fetch high byte
        t2   // Execute
    } seqState_t;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
        logic o;
    } flags_t;

    typedef struct packed {
        aluOp_t   aluOp;
        logic     flagsEn;
        logic     regWrEn;
        regCode_t regWrCode;
        wrSrc_t   wrSrc;
        regCode_t rdCodeA;
        regCode_t rdCodeB;   // Also feeds store data
        logic     pcInc;
        logic     pcLoad;    // PC takes the immediate
        addrSel_t addrSel;
        logic     memRead;
        logic     memWrite;
    } ctrlWord_t;

    typedef struct packed {
        byte_t addr;
        byte_t wrData;
        logic  csN;  // Active low chip select
        logic  wr;   // 1 write, 0 read
    } memReq_t;

endpackage
